//--- sources.f
verilog/lookup_pkg.sv
verilog/entry_index_counter.sv
verilog/match_cam.sv
verilog/action_table.sv
verilog/lookup_pipe.sv
verilog/ctrl_fsm.sv
verilog/lookup_engine.sv
bench/tb_clock.sv
bench/lookup_engine_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the lookup stage testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    --top-module lookup_engine_tb \
    -f sources.f \
    -o sim_lookup_engine

# a failing run exits non-zero, the log search below gives the verdict
./obj_dir/sim_lookup_engine > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
    echo "simulation ok"
else
    echo "simulation FAILED, see sim.log"
    exit 1
fi

//--- bench/lookup_stim.txt
// op 1 control word: 1 <last> <data>, op 2 lookup: 2 <key> <mask> <expected action>
// op 3 idle: 3 <cycles>, op 0 ends the stimulus; all values hex
3 2
// empty tables miss
2 12345678 ffffffff 3f
2 00000000 00000000 3f
2 a0000001 ffffffff 3f
// key table, entries 4 to 6
1 0 0200f2f100000004
1 0 a0000001
1 0 a0000002
1 1 a00000f1
// action table, entries 4 to 6
1 0 0210f2f100000004
1 0 111100000004
1 0 222200000005
1 1 333300000006
3 1
// exact, masked and priority lookups back to back
2 a0000001 ffffffff 111100000004
2 a0000002 ffffffff 222200000005
2 a00000f1 ffffffff 333300000006
2 a0000003 fffffff0 111100000004
2 30000002 0fffffff 222200000005
2 a0000012 ffffffff 3f
2 b0000001 ffffffff 3f
2 a00000f1 ffffff00 111100000004
2 000000f1 000000ff 333300000006
// wrong stage, wrong lookup id, wrong flag
1 0 0a00f2f100000007
1 1 00000000deadbeef
1 0 0300f2f100000004
1 1 0000000055555555
1 0 0200f2f200000005
1 0 0000000066666666
1 1 0000000077777777
3 2
2 deadbeef ffffffff 3f
2 a0000001 ffffffff 111100000004
2 a0000002 ffffffff 222200000005
2 a00000f1 ffffffff 333300000006
2 00000000 00000000 111100000004
0

//--- bench/lookup_engine_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// stimulus is read from bench/lookup_stim.txt, so run from the project root
// inputs are driven and outputs sampled on the falling clock edge
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module lookup_engine_tb;

    import lookup_pkg::*;

    localparam int STIM_WORDS      = 512;
    localparam int RESET_CYCLES    = 3;
    localparam int LOOKUP_LATENCY  = 2;
    localparam int FORWARD_LATENCY = 1;
    localparam int DRAIN_TIMEOUT   = 16;
    localparam int MAX_IDLE        = 1000;
    localparam int DEPTH           = 16;

    // identity of this stage and the table loading rules
    localparam logic [4:0]  MY_STAGE    = 5'd0;
    localparam logic [2:0]  MY_LOOKUP   = 3'd2;
    localparam logic [15:0] LOAD_FLAG   = 16'hf2f1;
    localparam action_t     MISS_ACTION = 48'h3f;
    localparam logic [31:0] LFSR_SEED   = 32'd81799;

    localparam int KIND_FWD = 0;
    localparam int KIND_KEY = 1;
    localparam int KIND_ACT = 2;

    logic       clk;
    logic       rst_n;
    key_t       key;
    key_t       mask;
    phv_t       phv;
    logic       key_valid;
    action_t    action;
    phv_t       phv_out;
    logic       action_valid;
    ctrl_word_t ctrl_in_data;
    logic       ctrl_in_valid;
    logic       ctrl_in_last;
    ctrl_word_t ctrl_out_data;
    logic       ctrl_out_valid;
    logic       ctrl_out_last;

    logic [63:0] stim_words [STIM_WORDS];
    int          cycle;
    logic [31:0] lfsr_state;

    // reference copy of both tables
    key_t    model_key       [DEPTH];
    logic    model_key_valid [DEPTH];
    action_t model_act       [DEPTH];
    logic    model_act_set   [DEPTH];
    logic    pkt_open;
    int      pkt_kind;
    int      pkt_index;

    // results still in flight and the cycle each one is due
    action_t    exp_action [$];
    phv_t       exp_phv    [$];
    int         look_due   [$];
    ctrl_word_t exp_ctrl   [$];
    logic       exp_last   [$];
    int         ctrl_due   [$];

    tb_clock #(
        .PERIOD_NS (100)
    ) tb_clock_i (
        .clk (clk)
    );

    lookup_engine #(
        .STAGE_ID    (5'd0),
        .LOOKUP_ID   (3'd2),
        .TABLE_DEPTH (16)
    ) dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .key            (key),
        .mask           (mask),
        .phv            (phv),
        .key_valid      (key_valid),
        .action         (action),
        .phv_out        (phv_out),
        .action_valid   (action_valid),
        .ctrl_in_data   (ctrl_in_data),
        .ctrl_in_valid  (ctrl_in_valid),
        .ctrl_in_last   (ctrl_in_last),
        .ctrl_out_data  (ctrl_out_data),
        .ctrl_out_valid (ctrl_out_valid),
        .ctrl_out_last  (ctrl_out_last)
    );

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        abort_run();
    endtask

    task automatic check_action(input string name, input action_t got, input action_t exp);
        if (got !== exp) begin
            $display("error at time %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_phv(input string name, input phv_t got, input phv_t exp);
        if (got !== exp) begin
            $display("error at time %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_ctrl(input string name, input ctrl_word_t got, input ctrl_word_t exp);
        if (got !== exp) begin
            $display("error at time %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at time %0t: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // fibonacci lfsr for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic next_phv(output phv_t v);
        v = '0;
        for (int i = 0; i < $bits(phv_t); i++) begin
            v          = {v[$bits(phv_t)-2:0], lfsr_state[31]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic expect_forward(input ctrl_word_t data, input logic last);
        exp_ctrl.push_back(data);
        exp_last.push_back(last);
        ctrl_due.push_back(cycle + FORWARD_LATENCY);
    endtask

    // header holds stage 63:59, lookup 58:56, table select 55:52, flag 47:32 and index 7:0
    task automatic model_ctrl_word(input ctrl_word_t data, input logic last);
        if (!pkt_open) begin
            if (data[63:59] == MY_STAGE && data[58:56] == MY_LOOKUP
                    && data[47:32] == LOAD_FLAG) begin
                pkt_kind  = (data[55:52] == 4'd0) ? KIND_KEY : KIND_ACT;
                pkt_index = int'(data[7:0]) % DEPTH;
            end else begin
                pkt_kind = KIND_FWD;
                expect_forward(data, last);
            end
        end else if (pkt_kind == KIND_FWD) begin
            expect_forward(data, last);
        end else begin
            if (pkt_kind == KIND_KEY) begin
                model_key[pkt_index]       = data[31:0];
                model_key_valid[pkt_index] = 1'b1;
            end else begin
                model_act[pkt_index]     = data[47:0];
                model_act_set[pkt_index] = 1'b1;
            end
            pkt_index = (pkt_index + 1) % DEPTH;
        end
        pkt_open = !last;
    endtask

    task automatic predict_action(input key_t k, input key_t m, output action_t a,
                                  output logic known);
        int slot;
        slot = 0;
        // first slot from the bottom whose masked key agrees
        while (slot < DEPTH
               && !(model_key_valid[slot] && ((model_key[slot] & m) == (k & m)))) begin
            slot++;
        end
        if (slot == DEPTH) begin
            a     = MISS_ACTION;
            known = 1'b1;
        end else begin
            a     = model_act[slot];
            known = model_act_set[slot];
        end
    endtask

    task automatic sample_outputs();
        if (look_due.size() > 0 && look_due[0] == cycle) begin
            if (action_valid !== 1'b1) begin
                report_failure("action_valid did not rise 2 cycles after key_valid");
            end else begin
                check_action("action", action, exp_action[0]);
                check_phv("phv_out", phv_out, exp_phv[0]);
                void'(exp_action.pop_front());
                void'(exp_phv.pop_front());
                void'(look_due.pop_front());
            end
        end else if (action_valid !== 1'b0) begin
            report_failure("action_valid is high although no lookup is due in this cycle");
        end

        if (ctrl_due.size() > 0 && ctrl_due[0] == cycle) begin
            if (ctrl_out_valid !== 1'b1) begin
                report_failure("a forwarded control word did not appear 1 cycle after it arrived");
            end else begin
                check_ctrl("ctrl_out_data", ctrl_out_data, exp_ctrl[0]);
                check_bit("ctrl_out_last", ctrl_out_last, exp_last[0]);
                void'(exp_ctrl.pop_front());
                void'(exp_last.pop_front());
                void'(ctrl_due.pop_front());
            end
        end else if (ctrl_out_valid !== 1'b0) begin
            report_failure("ctrl_out_valid is high although no forwarded word is due");
        end
    endtask

    task automatic advance_cycle();
        @(negedge clk);
        cycle++;
        sample_outputs();
    endtask

    task automatic drive_quiet();
        key_valid     = 1'b0;
        ctrl_in_valid = 1'b0;
        ctrl_in_last  = 1'b0;
    endtask

    task automatic run_idle(input int n);
        for (int i = 0; i < n; i++) begin
            advance_cycle();
            drive_quiet();
        end
    endtask

    task automatic run_ctrl(input ctrl_word_t data, input logic last);
        advance_cycle();
        key_valid     = 1'b0;
        ctrl_in_data  = data;
        ctrl_in_valid = 1'b1;
        ctrl_in_last  = last;
        model_ctrl_word(data, last);
    endtask

    task automatic run_lookup(input key_t k, input key_t m, input action_t file_exp);
        action_t model_exp;
        logic    known;
        phv_t    new_phv;
        predict_action(k, m, model_exp, known);
        if (!known) begin
            report_failure("stimulus looks up an entry whose action was never loaded");
        end else if (model_exp !== file_exp) begin
            report_failure("stimulus file and reference model disagree on an expected action");
        end else begin
            next_phv(new_phv);
            advance_cycle();
            key           = k;
            mask          = m;
            phv           = new_phv;
            key_valid     = 1'b1;
            ctrl_in_valid = 1'b0;
            ctrl_in_last  = 1'b0;
            exp_action.push_back(file_exp);
            exp_phv.push_back(new_phv);
            look_due.push_back(cycle + LOOKUP_LATENCY);
        end
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        while (look_due.size() > 0 || ctrl_due.size() > 0) begin
            if (waited == DRAIN_TIMEOUT) begin
                report_failure("timeout waiting for lookup results or forwarded control words");
            end else begin
                advance_cycle();
                drive_quiet();
                waited++;
            end
        end
    endtask

    initial begin
        int          ptr;
        int          lookups;
        logic        done;
        logic [63:0] op;

        rst_n         = 1'b0;
        key           = '0;
        mask          = '0;
        phv           = '0;
        key_valid     = 1'b0;
        ctrl_in_data  = '0;
        ctrl_in_valid = 1'b0;
        ctrl_in_last  = 1'b0;
        cycle         = 0;
        lfsr_state    = LFSR_SEED;
        pkt_open      = 1'b0;
        pkt_kind      = KIND_FWD;
        pkt_index     = 0;
        for (int i = 0; i < DEPTH; i++) begin
            model_key[i]       = '0;
            model_key_valid[i] = 1'b0;
            model_act[i]       = '0;
            model_act_set[i]   = 1'b0;
        end
        $readmemh("bench/lookup_stim.txt", stim_words);

        // reset spans 3 rising edges, outputs are first sampled once it has acted
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
        end
        advance_cycle();
        rst_n = 1'b1;

        ptr     = 0;
        lookups = 0;
        done    = 1'b0;
        while (!done) begin
            op = stim_words[ptr];
            if ($isunknown(op) || ptr + 4 > STIM_WORDS) begin
                report_failure("stimulus file is unreadable or has no end marker");
            end else if (op == 64'd0) begin
                done = 1'b1;
            end else if (op == 64'd1) begin
                run_ctrl(stim_words[ptr + 2], stim_words[ptr + 1][0]);
                ptr += 3;
            end else if (op == 64'd2) begin
                run_lookup(stim_words[ptr + 1][31:0], stim_words[ptr + 2][31:0],
                           stim_words[ptr + 3][47:0]);
                lookups++;
                ptr += 4;
            end else if (op == 64'd3 && stim_words[ptr + 1] <= 64'(MAX_IDLE)) begin
                run_idle(int'(stim_words[ptr + 1]));
                ptr += 2;
            end else begin
                report_failure("stimulus file holds an unknown operation or a too long idle");
            end
        end

        drain_results();
        // a few quiet cycles catch stray valids
        run_idle(3);

        if (lookups == 0) begin
            report_failure("stimulus file held no lookups");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
// ~~~~~~~~~~~~~~~~~~~~
// free-running clock, starts low, period in ns
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2);
        clk = ~clk;
    end

endmodule

`default_nettype wire

//--- verilog/lookup_engine.sv
// ~~~~~~~~~~~~~~~~~~~~
// no back-pressure on either stream, one word or key per cycle
// action_valid follows key_valid by 2 cycles
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module lookup_engine #(
    parameter logic [lookup_pkg::STAGE_W-1:0]  STAGE_ID    = 5'd0,
    parameter logic [lookup_pkg::LOOKUP_W-1:0] LOOKUP_ID   = 3'd2,
    parameter int                              TABLE_DEPTH = 16
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    // lookup side
    input  wire lookup_pkg::key_t       key,
    input  wire lookup_pkg::key_t       mask,
    input  wire lookup_pkg::phv_t       phv,
    input  wire logic                   key_valid,
    output lookup_pkg::action_t         action,
    output lookup_pkg::phv_t            phv_out,
    output logic                        action_valid,

    // control stream
    input  wire lookup_pkg::ctrl_word_t ctrl_in_data,
    input  wire logic                   ctrl_in_valid,
    input  wire logic                   ctrl_in_last,
    output lookup_pkg::ctrl_word_t      ctrl_out_data,
    output logic                        ctrl_out_valid,
    output logic                        ctrl_out_last
);

    import lookup_pkg::*;

    logic         cam_we;
    logic         act_we;
    ctrl_word_t   wr_data;
    logic         index_load;
    logic         index_step;
    table_index_t start_index;
    table_index_t wr_index;

    ctrl_fsm #(
        .STAGE_ID  (STAGE_ID),
        .LOOKUP_ID (LOOKUP_ID)
    ) ctrl_fsm_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .ctrl_in_data   (ctrl_in_data),
        .ctrl_in_valid  (ctrl_in_valid),
        .ctrl_in_last   (ctrl_in_last),
        .ctrl_out_data  (ctrl_out_data),
        .ctrl_out_valid (ctrl_out_valid),
        .ctrl_out_last  (ctrl_out_last),
        .cam_we         (cam_we),
        .act_we         (act_we),
        .wr_data        (wr_data),
        .index_load     (index_load),
        .index_step     (index_step),
        .start_index    (start_index)
    );

    entry_index_counter #(
        .TABLE_DEPTH (TABLE_DEPTH)
    ) entry_index_counter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .index_load  (index_load),
        .index_step  (index_step),
        .start_index (start_index),
        .wr_index    (wr_index)
    );

    lookup_pipe #(
        .TABLE_DEPTH (TABLE_DEPTH)
    ) lookup_pipe_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .key          (key),
        .mask         (mask),
        .phv          (phv),
        .key_valid    (key_valid),
        .action       (action),
        .phv_out      (phv_out),
        .action_valid (action_valid),
        .cam_we       (cam_we),
        .act_we       (act_we),
        .wr_data      (wr_data),
        .wr_index     (wr_index)
    );

endmodule

`default_nettype wire

//--- verilog/ctrl_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~
// first valid word of a packet is the header, decided in its own cycle
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ctrl_fsm #(
    parameter logic [lookup_pkg::STAGE_W-1:0]  STAGE_ID  = 5'd0,
    parameter logic [lookup_pkg::LOOKUP_W-1:0] LOOKUP_ID = 3'd2
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    input  wire lookup_pkg::ctrl_word_t ctrl_in_data,
    input  wire logic                   ctrl_in_valid,
    input  wire logic                   ctrl_in_last,
    output lookup_pkg::ctrl_word_t      ctrl_out_data,
    output logic                        ctrl_out_valid,
    output logic                        ctrl_out_last,

    // table write requests
    output logic                        cam_we,
    output logic                        act_we,
    output lookup_pkg::ctrl_word_t      wr_data,
    output logic                        index_load,
    output logic                        index_step,
    output lookup_pkg::table_index_t    start_index
);

    import lookup_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_KEY,
        ST_ACT,
        ST_FWD
    } state_t;

    state_t              state;
    logic [STAGE_W-1:0]  hdr_stage;
    logic [LOOKUP_W-1:0] hdr_lookup;
    logic [RESV_W-1:0]   hdr_resv;
    logic [FLAG_W-1:0]   hdr_flag;
    logic                hdr_match;
    logic                in_entry;
    logic                first_word;
    logic                forward;

    // header fields, only meaningful in idle
    assign hdr_stage   = ctrl_in_data[HDR_STAGE_LSB +: STAGE_W];
    assign hdr_lookup  = ctrl_in_data[HDR_LOOKUP_LSB +: LOOKUP_W];
    assign hdr_resv    = ctrl_in_data[HDR_RESV_LSB +: RESV_W];
    assign hdr_flag    = ctrl_in_data[HDR_FLAG_LSB +: FLAG_W];
    assign start_index = ctrl_in_data[HDR_INDEX_LSB +: INDEX_W];

    assign hdr_match = (hdr_stage == STAGE_ID) && (hdr_lookup == LOOKUP_ID)
                       && (hdr_flag == CTRL_FLAG);

    assign in_entry = (state == ST_KEY) || (state == ST_ACT);
    assign forward  = ctrl_in_valid
                      && (((state == ST_IDLE) && !hdr_match) || (state == ST_FWD));

    // load on the header, step on every data word but the first
    assign index_load = (state == ST_IDLE) && ctrl_in_valid && hdr_match;
    assign index_step = in_entry && ctrl_in_valid && !first_word;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= ST_IDLE;
            first_word     <= 1'b0;
            cam_we         <= 1'b0;
            act_we         <= 1'b0;
            ctrl_out_valid <= 1'b0;
            ctrl_out_last  <= 1'b0;
        end else begin
            cam_we         <= (state == ST_KEY) && ctrl_in_valid;
            act_we         <= (state == ST_ACT) && ctrl_in_valid;
            ctrl_out_valid <= forward;
            ctrl_out_last  <= forward && ctrl_in_last;

            case (state)
                ST_IDLE: begin
                    // a one-word packet leaves us in idle
                    if (ctrl_in_valid && !ctrl_in_last) begin
                        if (hdr_match) begin
                            first_word <= 1'b1;
                            state      <= (hdr_resv == '0) ? ST_KEY : ST_ACT;
                        end else begin
                            state <= ST_FWD;
                        end
                    end
                end
                ST_KEY, ST_ACT: begin
                    if (ctrl_in_valid) begin
                        first_word <= 1'b0;
                        if (ctrl_in_last) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                ST_FWD: begin
                    if (ctrl_in_valid && ctrl_in_last) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (forward) begin
            ctrl_out_data <= ctrl_in_data;
        end
        if (in_entry && ctrl_in_valid) begin
            wr_data <= ctrl_in_data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/lookup_pipe.sv
// ~~~~~~~~~~~~~~~~~~~~
// fixed 2-cycle pipeline, a new key may enter every cycle
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module lookup_pipe #(
    parameter int TABLE_DEPTH = 16
) (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire lookup_pkg::key_t          key,
    input  wire lookup_pkg::key_t          mask,
    input  wire lookup_pkg::phv_t          phv,
    input  wire logic                      key_valid,
    output lookup_pkg::action_t            action,
    output lookup_pkg::phv_t               phv_out,
    output logic                           action_valid,
    input  wire logic                      cam_we,
    input  wire logic                      act_we,
    input  wire lookup_pkg::ctrl_word_t    wr_data,
    input  wire lookup_pkg::table_index_t  wr_index
);

    import lookup_pkg::*;

    logic         s1_valid;
    phv_t         s1_phv;
    logic         cam_hit;
    table_index_t cam_hit_index;

    // stage 1 is the compare
    match_cam #(
        .TABLE_DEPTH (TABLE_DEPTH)
    ) match_cam_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .key       (key),
        .mask      (mask),
        .cam_we    (cam_we),
        .wr_data   (wr_data),
        .wr_index  (wr_index),
        .hit       (cam_hit),
        .hit_index (cam_hit_index)
    );

    // stage 2 is the action read
    action_table #(
        .TABLE_DEPTH (TABLE_DEPTH)
    ) action_table_i (
        .clk       (clk),
        .act_we    (act_we),
        .wr_data   (wr_data),
        .wr_index  (wr_index),
        .hit       (cam_hit),
        .hit_index (cam_hit_index),
        .action    (action)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid     <= 1'b0;
            action_valid <= 1'b0;
        end else begin
            s1_valid     <= key_valid;
            action_valid <= s1_valid;
        end
    end

    // phv rides along with its key
    always_ff @(posedge clk) begin
        s1_phv  <= phv;
        phv_out <= s1_phv;
    end

endmodule

`default_nettype wire

//--- verilog/action_table.sv
// ~~~~~~~~~~~~~~~~~~~~
// read data is old content when read and write hit one address together
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module action_table #(
    parameter int TABLE_DEPTH = 16
) (
    input  wire logic                      clk,
    input  wire logic                      act_we,
    input  wire lookup_pkg::ctrl_word_t    wr_data,
    input  wire lookup_pkg::table_index_t  wr_index,
    input  wire logic                      hit,
    input  wire lookup_pkg::table_index_t  hit_index,
    output lookup_pkg::action_t            action
);

    import lookup_pkg::*;

    localparam int ADDR_W = $clog2(TABLE_DEPTH);

    action_t mem [TABLE_DEPTH];
    action_t rd_action;
    logic    rd_hit;

    always_ff @(posedge clk) begin
        if (act_we) begin
            mem[wr_index[ADDR_W-1:0]] <= wr_data[ACTION_W-1:0];
        end
        rd_action <= mem[hit_index[ADDR_W-1:0]];
        rd_hit    <= hit;
    end

    // miss falls back to the default action
    assign action = rd_hit ? rd_action : DEFAULT_ACTION;

endmodule

`default_nettype wire

//--- verilog/match_cam.sv
// ~~~~~~~~~~~~~~~~~~~~
// binary CAM, mask bit 1 means compare; lowest hitting address wins
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module match_cam #(
    parameter int TABLE_DEPTH = 16
) (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire lookup_pkg::key_t          key,
    input  wire lookup_pkg::key_t          mask,
    input  wire logic                      cam_we,
    input  wire lookup_pkg::ctrl_word_t    wr_data,
    input  wire lookup_pkg::table_index_t  wr_index,
    output logic                           hit,
    output lookup_pkg::table_index_t       hit_index
);

    import lookup_pkg::*;

    localparam int ADDR_W = $clog2(TABLE_DEPTH);

    key_t                   entry_key [TABLE_DEPTH];
    logic [TABLE_DEPTH-1:0] entry_valid;
    logic [TABLE_DEPTH-1:0] hit_vec;
    logic                   pick_hit;
    table_index_t           pick_index;

    always_ff @(posedge clk) begin
        if (cam_we) begin
            entry_key[wr_index[ADDR_W-1:0]] <= wr_data[KEY_W-1:0];
        end
    end

    // entries stay valid once written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (cam_we) begin
            entry_valid[wr_index[ADDR_W-1:0]] <= 1'b1;
        end
    end

    always_comb begin
        pick_hit   = 1'b0;
        pick_index = '0;
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            hit_vec[i] = entry_valid[i] && (((entry_key[i] ^ key) & mask) == '0);
        end
        // scan downwards so the lowest hit is left standing
        for (int i = TABLE_DEPTH - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                pick_hit   = 1'b1;
                pick_index = table_index_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit <= 1'b0;
        end else begin
            hit <= pick_hit;
        end
    end

    always_ff @(posedge clk) begin
        hit_index <= pick_index;
    end

endmodule

`default_nettype wire

//--- verilog/entry_index_counter.sv
// ~~~~~~~~~~~~~~~~~~~~
// load wins over step, stepping wraps at TABLE_DEPTH
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module entry_index_counter #(
    parameter int TABLE_DEPTH = 16
) (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      index_load,
    input  wire logic                      index_step,
    input  wire lookup_pkg::table_index_t  start_index,
    output lookup_pkg::table_index_t       wr_index
);

    import lookup_pkg::*;

    localparam table_index_t LAST_INDEX = table_index_t'(TABLE_DEPTH - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_index <= '0;
        end else if (index_load) begin
            wr_index <= start_index;
        end else if (index_step) begin
            if (wr_index >= LAST_INDEX) begin
                wr_index <= '0;
            end else begin
                wr_index <= wr_index + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/lookup_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// widths and header layout are shared by every block of the lookup stage
// header fields sit in the first control word, data words are used unswapped
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package lookup_pkg;

    // payload widths
    localparam int KEY_W    = 32;
    localparam int PHV_W    = 64;
    localparam int ACTION_W = 48;
    localparam int CTRL_W   = 64;
    localparam int INDEX_W  = 8;

    typedef logic [KEY_W-1:0]    key_t;
    typedef logic [PHV_W-1:0]    phv_t;
    typedef logic [ACTION_W-1:0] action_t;
    typedef logic [CTRL_W-1:0]   ctrl_word_t;
    typedef logic [INDEX_W-1:0]  table_index_t;

    // header field widths
    localparam int STAGE_W  = 5;
    localparam int LOOKUP_W = 3;
    localparam int RESV_W   = 4;
    localparam int FLAG_W   = 16;

    // header field positions
    localparam int HDR_STAGE_LSB  = 59;
    localparam int HDR_LOOKUP_LSB = 56;
    localparam int HDR_RESV_LSB   = 52;
    localparam int HDR_FLAG_LSB   = 32;
    localparam int HDR_INDEX_LSB  = 0;

    // action on a table miss
    localparam action_t DEFAULT_ACTION = 48'h3f;

    // marks a control packet meant for table loading
    localparam logic [FLAG_W-1:0] CTRL_FLAG = 16'hf2f1;

endpackage

`default_nettype wire
